// ==== build.f ====
hdl/riscvPkg.sv
hdl/alu.sv
hdl/immExtend.sv
hdl/regFile.sv
hdl/dataMem.sv
hdl/controller.sv
hdl/datapath.sv
hdl/riscvCore.sv
tb/riscvCore_asserts.sv
tb/coreTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module coreTb -f build.f -o coreTbSim

# simulator status is not trusted, the log decides
./obj_dir/coreTbSim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Done: no errors$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== tb/coreTb.sv ====
// testbench for the single-cycle core with a random program checked against a reference model
`timescale 1ns/1ps
`default_nettype none

module coreTb;
    import riscvPkg::*;

    localparam int resetCycles = 5;
    localparam int runCycles   = 2000;
    localparam int clkPeriod   = 20;
    localparam int dataWords   = 64;
    localparam int progWords   = 256;

    logic        clk;
    logic        rstN;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        memWrite;
    logic [31:0] dataAdr;
    logic [31:0] writeData;

    // program image and reference state
    logic [31:0] prog [progWords];
    logic [31:0] mregs [32];
    logic [31:0] mdata [dataWords];
    logic [31:0] mpc;
    logic [31:0] cur;
    int          errorCount;

    riscvCore #(
        .dataWords (dataWords)
    ) uut (
        .clk       (clk),
        .rstN      (rstN),
        .instr     (instr),
        .pc        (pc),
        .memWrite  (memWrite),
        .dataAdr   (dataAdr),
        .writeData (writeData)
    );

    always #(clkPeriod / 2) clk = ~clk;

    task automatic reportMismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        errorCount++;
        $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
    endtask

    // maps a 2-bit pick onto the supported funct3 codes
    function automatic logic [2:0] pickFunct3(input logic [1:0] sel);
        case (sel)
            2'd0:    return 3'b000;
            2'd1:    return 3'b010;
            2'd2:    return 3'b110;
            default: return 3'b111;
        endcase
    endfunction

    // instruction encoders in isa field order
    function automatic logic [31:0] encodeI(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [2:0] f3, input logic [4:0] rd,
                                            input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encodeS(input logic [11:0] imm, input logic [4:0] rs2,
                                            input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore};
    endfunction

    function automatic logic [31:0] encodeB(input logic [12:0] imm, input logic [4:0] rs2,
                                            input logic [4:0] rs1);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], opBranch};
    endfunction

    function automatic logic [31:0] encodeJ(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
    endfunction

    // one random legal instruction of the subset
    function automatic logic [31:0] genInstr();
        logic [31:0] r;
        logic [31:0] pick;
        logic [31:0] immV;
        logic [31:0] offW;
        logic [2:0]  f3;
        logic [4:0]  rs2;
        r    = $urandom;
        pick = $urandom_range(0, 99);
        // small immediates of about +-64
        immV = $urandom_range(0, 127) - 32'd64;
        f3   = pickFunct3(r[17:16]);
        rs2  = r[14:10];
        if (pick < 12)
            return encodeI(immV[11:0], r[9:5], 3'b010, r[4:0], opLoad);
        else if (pick < 28)
            return encodeS(immV[11:0], rs2, r[9:5]);
        else if (pick < 50)
            return {(f3 == 3'b000 && r[18]) ? 7'h20 : 7'h00, rs2, r[9:5], f3, r[4:0], opRtype};
        else if (pick < 75)
            return encodeI(immV[11:0], r[9:5], f3, r[4:0], opItype);
        else if (pick < 90)
        begin
            // same register is always taken so its offset only goes forward
            if (r[19])
            begin
                rs2  = r[9:5];
                offW = $urandom_range(1, 32);
            end
            else
            begin
                offW = $urandom_range(0, 40) - 32'd8;
                if (offW == 32'd0)
                    offW = 32'd1;
            end
            immV = offW << 2;
            return encodeB(immV[12:0], rs2, r[9:5]);
        end
        offW = $urandom_range(1, 32);
        immV = offW << 2;
        return encodeJ(immV[20:0], r[4:0]);
    endfunction

    // executes the instruction at mpc on the reference state
    task automatic executeModel();
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immB;
        logic [31:0] immJ;
        logic [31:0] addr;
        logic [31:0] res;
        logic [31:0] nextPc;
        logic        wr;
        w      = prog[mpc[9:2]];
        a      = mregs[w[19:15]];
        b      = mregs[w[24:20]];
        immI   = {{20{w[31]}}, w[31:20]};
        immS   = {{20{w[31]}}, w[31:25], w[11:7]};
        immB   = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        immJ   = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        nextPc = mpc + 32'd4;
        res    = 32'd0;
        wr     = 1'b0;
        case (w[6:0])
            opLoad:
            begin
                addr = a + immI;
                res  = mdata[addr[7:2]];
                wr   = 1'b1;
            end
            opStore:
            begin
                addr = a + immS;
                mdata[addr[7:2]] = b;
            end
            opRtype, opItype:
            begin
                // sub only with r-type funct7 bit 5
                if (w[6:0] == opItype)
                    b = immI;
                case (w[14:12])
                    3'b000:  res = (w[6:0] == opRtype && w[30]) ? a - b : a + b;
                    3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    3'b110:  res = a | b;
                    default: res = a & b;
                endcase
                wr = 1'b1;
            end
            opBranch:
            begin
                if (a == b)
                    nextPc = mpc + immB;
            end
            opJal:
            begin
                res    = mpc + 32'd4;
                wr     = 1'b1;
                nextPc = mpc + immJ;
            end
            default:
            begin
                wr = 1'b0;
            end
        endcase
        // x0 never written
        if (wr && w[11:7] != 5'd0)
            mregs[w[11:7]] = res;
        mpc = nextPc;
    endtask

    // model advances with the dut and serves the instruction at the new pc
    always @(posedge clk)
    begin
        if (rstN)
            executeModel();
        instr <= prog[mpc[9:2]];
    end

    // outputs settle by the falling edge
    always @(negedge clk)
    begin
        if (!rstN)
        begin
            if (pc !== 32'd0)
                reportMismatch("resetPc", 32'd0, pc);
            if (memWrite !== 1'b0)
                reportMismatch("resetMemWrite", 32'd0, {31'd0, memWrite});
        end
        else
        begin
            cur = prog[mpc[9:2]];
            if (pc !== mpc)
                reportMismatch("pcFlow", mpc, pc);
            if (cur[6:0] == opStore)
            begin
                if (memWrite !== 1'b1)
                    reportMismatch("storeStrobe", 32'd1, {31'd0, memWrite});
                if (dataAdr !== mregs[cur[19:15]] + {{20{cur[31]}}, cur[31:25], cur[11:7]})
                    reportMismatch("storeAddress",
                                   mregs[cur[19:15]] + {{20{cur[31]}}, cur[31:25], cur[11:7]},
                                   dataAdr);
                if (writeData !== mregs[cur[24:20]])
                    reportMismatch("storeData", mregs[cur[24:20]], writeData);
            end
            else if (memWrite !== 1'b0)
            begin
                reportMismatch("noStore", 32'd0, {31'd0, memWrite});
            end
        end
    end

    initial
    begin
        clk        = 1'b0;
        rstN       = 1'b0;
        instr      = 32'd0;
        errorCount = 0;
        mpc        = 32'd0;
        for (int i = 0; i < 32; i++)
            mregs[i] = 32'd0;
        for (int i = 0; i < dataWords; i++)
            mdata[i] = 32'd0;
        void'($urandom(32'h7e08));
        for (int i = 0; i < progWords; i++)
            prog[i] = genInstr();
        // first word is served during reset so it must not be a store
        prog[0] = encodeI(12'd5, 5'd0, 3'b000, 5'd1, opItype);
        repeat (resetCycles) @(posedge clk);
        rstN <= 1'b1;
        repeat (runCycles) @(posedge clk);
        // the last falling-edge check has finished by this edge
        @(posedge clk);
        $display("errors: %0d", errorCount);
        if (errorCount == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    // watchdog a little past the full run length
    initial
    begin
        #((resetCycles + runCycles + 10) * clkPeriod);
        $display("timeout: the run did not reach its end in time");
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/riscvCore_asserts.sv ====
// port-level assertions for the core, bound into every riscvCore instance
`timescale 1ns/1ps
`default_nettype none

module riscvCore_asserts (
    input wire        clk,
    input wire        rstN,
    input wire [31:0] pc,
    input wire        memWrite,
    input wire [31:0] dataAdr,
    input wire [31:0] writeData
);

    // instructions are words, so pc never leaves a word boundary
    pcAligned: assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00)
        else $error("pc not word aligned: %h", pc);

    // store strobe always driven
    memWriteKnown: assert property (@(posedge clk) disable iff (!rstN) !$isunknown(memWrite))
        else $error("memWrite unknown");

    // store address and data valid with the strobe
    storeKnown: assert property (@(posedge clk) disable iff (!rstN)
        memWrite |-> !$isunknown({dataAdr, writeData}))
        else $error("store address or data unknown");

endmodule

bind riscvCore riscvCore_asserts uAsserts (
    .clk       (clk),
    .rstN      (rstN),
    .pc        (pc),
    .memWrite  (memWrite),
    .dataAdr   (dataAdr),
    .writeData (writeData)
);

`default_nettype wire

// ==== hdl/riscvCore.sv ====
// single-cycle rv32i subset core with internal data memory
`timescale 1ns/1ps
`default_nettype none

module riscvCore #(
    parameter int dataWords = 64
) (
    input  wire         clk,
    input  wire         rstN,
    input  wire  [31:0] instr,
    output logic [31:0] pc,
    output logic        memWrite,
    output logic [31:0] dataAdr,
    output logic [31:0] writeData
);
    import riscvPkg::*;

    // decode to datapath controls
    logic        regWrite;
    logic        aluSrc;
    logic        pcSrc;
    logic        zero;
    resultSrcT   resultSrc;
    immSrcT      immSrc;
    aluCtrlT     aluControl;
    logic [31:0] readData;

    controller uController (
        .instr      (instr),
        .zero       (zero),
        .regWrite   (regWrite),
        .memWrite   (memWrite),
        .aluSrc     (aluSrc),
        .resultSrc  (resultSrc),
        .immSrc     (immSrc),
        .aluControl (aluControl),
        .pcSrc      (pcSrc)
    );

    // alu result doubles as the data address
    datapath uDatapath (
        .clk        (clk),
        .rstN       (rstN),
        .instr      (instr),
        .regWrite   (regWrite),
        .aluSrc     (aluSrc),
        .resultSrc  (resultSrc),
        .immSrc     (immSrc),
        .aluControl (aluControl),
        .pcSrc      (pcSrc),
        .readData   (readData),
        .pc         (pc),
        .aluResult  (dataAdr),
        .writeData  (writeData),
        .zero       (zero)
    );

    dataMem #(
        .dataWords (dataWords)
    ) uDataMem (
        .clk  (clk),
        .rstN (rstN),
        .we   (memWrite),
        .adr  (dataAdr),
        .wd   (writeData),
        .rd   (readData)
    );

endmodule

`default_nettype wire

// ==== hdl/datapath.sv ====
// pc, register file, alu and result muxing of the single-cycle core
`timescale 1ns/1ps
`default_nettype none

module datapath (
    input  wire                      clk,
    input  wire                      rstN,
    input  wire riscvPkg::instrT     instr,
    input  wire                      regWrite,
    input  wire                      aluSrc,
    input  wire riscvPkg::resultSrcT resultSrc,
    input  wire riscvPkg::immSrcT    immSrc,
    input  wire riscvPkg::aluCtrlT   aluControl,
    input  wire                      pcSrc,
    input  wire [31:0]               readData,
    output logic [31:0]              pc,
    output logic [31:0]              aluResult,
    output logic [31:0]              writeData,
    output logic                     zero
);
    import riscvPkg::*;

    logic [31:0] pcNext;
    logic [31:0] pcPlus4;
    logic [31:0] pcTarget;
    logic [31:0] immExt;
    logic [31:0] srcA;
    logic [31:0] srcB;
    logic [31:0] result;

    // pc register
    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            pc <= 32'd0;
        end
        else
        begin
            pc <= pcNext;
        end
    end

    assign pcPlus4  = pc + 32'd4;
    // branch and jal share the target adder
    assign pcTarget = pc + immExt;
    assign pcNext   = pcSrc ? pcTarget : pcPlus4;

    regFile uRegFile (
        .clk  (clk),
        .rstN (rstN),
        .we   (regWrite),
        .ra1  (instr.rFmt.rs1),
        .ra2  (instr.rFmt.rs2),
        .wa   (instr.rFmt.rd),
        .wd   (result),
        .rd1  (srcA),
        .rd2  (writeData)
    );

    immExtend uImmExtend (
        .instr  (instr),
        .immSrc (immSrc),
        .immExt (immExt)
    );

    // register or immediate operand
    assign srcB = aluSrc ? immExt : writeData;

    alu uAlu (
        .a          (srcA),
        .b          (srcB),
        .aluControl (aluControl),
        .result     (aluResult),
        .zero       (zero)
    );

    // write-back select
    always_comb
    begin
        case (resultSrc)
            resMem:     result = readData;
            resPcPlus4: result = pcPlus4;
            default:    result = aluResult;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/controller.sv ====
// main decode, alu control decode and branch resolution of the core
`timescale 1ns/1ps
`default_nettype none

module controller (
    input  wire riscvPkg::instrT     instr,
    input  wire                      zero,
    output logic                     regWrite,
    output logic                     memWrite,
    output logic                     aluSrc,
    output riscvPkg::resultSrcT      resultSrc,
    output riscvPkg::immSrcT         immSrc,
    output riscvPkg::aluCtrlT        aluControl,
    output logic                     pcSrc
);
    import riscvPkg::*;

    // alu operation classes from the main decode
    localparam logic [1:0] aluOpAdd   = 2'b00;
    localparam logic [1:0] aluOpSub   = 2'b01;
    localparam logic [1:0] aluOpFunct = 2'b10;

    logic [6:0] opcode;
    logic [1:0] aluOp;
    logic       branch;
    logic       jump;
    logic       rtypeSub;

    assign opcode = instr.rFmt.opcode;

    // sub only for r-type with funct7 bit 5, never for addi
    assign rtypeSub = instr.rFmt.funct7[5] & opcode[5];

    // main decode
    always_comb
    begin
        // unknown opcodes: no write, no store, no branch
        regWrite  = 1'b0;
        memWrite  = 1'b0;
        aluSrc    = 1'b0;
        resultSrc = resAlu;
        immSrc    = immI;
        aluOp     = aluOpAdd;
        branch    = 1'b0;
        jump      = 1'b0;
        case (opcode)
            opLoad:
            begin
                regWrite  = 1'b1;
                aluSrc    = 1'b1;
                resultSrc = resMem;
            end
            opStore:
            begin
                memWrite = 1'b1;
                aluSrc   = 1'b1;
                immSrc   = immS;
            end
            opRtype:
            begin
                regWrite = 1'b1;
                aluOp    = aluOpFunct;
            end
            opItype:
            begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                aluOp    = aluOpFunct;
            end
            opBranch:
            begin
                // beq compares by subtracting
                immSrc = immB;
                aluOp  = aluOpSub;
                branch = 1'b1;
            end
            opJal:
            begin
                // link pc+4, target from pc adder
                regWrite  = 1'b1;
                resultSrc = resPcPlus4;
                immSrc    = immJ;
                jump      = 1'b1;
            end
            default:
            begin
                regWrite = 1'b0;
            end
        endcase
    end

    // alu control decode
    always_comb
    begin
        case (aluOp)
            aluOpAdd: aluControl = aluAdd;
            aluOpSub: aluControl = aluSub;
            default:
            begin
                case (instr.rFmt.funct3)
                    3'b000:  aluControl = rtypeSub ? aluSub : aluAdd;
                    3'b010:  aluControl = aluSlt;
                    3'b110:  aluControl = aluOr;
                    3'b111:  aluControl = aluAnd;
                    // funct3 outside the subset falls back to add
                    default: aluControl = aluAdd;
                endcase
            end
        endcase
    end

    // taken beq or any jal
    assign pcSrc = (branch & zero) | jump;

endmodule

`default_nettype wire

// ==== hdl/dataMem.sv ====
// word-addressed data memory, combinational read, cleared on reset
`timescale 1ns/1ps
`default_nettype none

module dataMem #(
    parameter int dataWords = 64
) (
    input  wire        clk,
    input  wire        rstN,
    input  wire        we,
    input  wire [31:0] adr,
    input  wire [31:0] wd,
    output logic [31:0] rd
);

    localparam int idxBits = $clog2(dataWords);

    logic [31:0]        mem [dataWords];
    logic [idxBits-1:0] idx;

    // byte offset ignored, upper bits wrap
    assign idx = adr[idxBits+1:2];

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            for (int i = 0; i < dataWords; i++)
            begin
                mem[i] <= 32'd0;
            end
        end
        else if (we)
        begin
            mem[idx] <= wd;
        end
    end

    assign rd = mem[idx];

endmodule

`default_nettype wire

// ==== hdl/regFile.sv ====
// 32 x 32 register file, two read ports, one write port, x0 tied to zero
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  wire        clk,
    input  wire        rstN,
    input  wire        we,
    input  wire [4:0]  ra1,
    input  wire [4:0]  ra2,
    input  wire [4:0]  wa,
    input  wire [31:0] wd,
    output logic [31:0] rd1,
    output logic [31:0] rd2
);

    logic [31:0] regs [32];

    // synchronous clear of every register
    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            for (int i = 0; i < 32; i++)
            begin
                regs[i] <= 32'd0;
            end
        end
        else if (we && (wa != 5'd0))
        begin
            // writes to x0 dropped
            regs[wa] <= wd;
        end
    end

    // combinational reads with x0 held at zero
    assign rd1 = (ra1 == 5'd0) ? 32'd0 : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? 32'd0 : regs[ra2];

endmodule

`default_nettype wire

// ==== hdl/immExtend.sv ====
// sign-extended immediate builder for i, s, b and j formats
`timescale 1ns/1ps
`default_nettype none

module immExtend (
    input  wire riscvPkg::instrT  instr,
    input  wire riscvPkg::immSrcT immSrc,
    output logic [31:0]           immExt
);
    import riscvPkg::*;

    // instruction bit 31 is the sign in every format
    logic signBit;

    assign signBit = instr.rFmt.funct7[6];

    always_comb
    begin
        case (immSrc)
            // loads and alu immediates
            immI: immExt = {{20{signBit}}, instr.iFmt.imm11to0};
            // store offset split around rs fields
            immS: immExt = {{20{signBit}}, instr.sFmt.imm11to5, instr.sFmt.imm4to0};
            // branch offset, halfword granular
            immB:
            begin
                immExt = {{20{signBit}}, instr.bFmt.imm11, instr.bFmt.imm10to5,
                          instr.bFmt.imm4to1, 1'b0};
            end
            // jal offset, 21 bits
            immJ:
            begin
                immExt = {{12{signBit}}, instr.jFmt.imm19to12, instr.jFmt.imm11,
                          instr.jFmt.imm10to1, 1'b0};
            end
            default: immExt = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/alu.sv ====
// 32-bit alu for add, sub, and, or and signed set-less-than
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire [31:0]             a,
    input  wire [31:0]             b,
    input  wire riscvPkg::aluCtrlT aluControl,
    output logic [31:0]            result,
    output logic                   zero
);
    import riscvPkg::*;

    logic lessThan;

    // signed compare for slt and slti
    assign lessThan = $signed(a) < $signed(b);

    always_comb
    begin
        case (aluControl)
            aluAdd:  result = a + b;
            aluSub:  result = a - b;
            aluAnd:  result = a & b;
            aluOr:   result = a | b;
            aluSlt:  result = {31'd0, lessThan};
            // unused codes
            default: result = 32'd0;
        endcase
    end

    // beq uses this after a subtract
    assign zero = (result == 32'd0);

endmodule

`default_nettype wire

// ==== hdl/riscvPkg.sv ====
// rv32i subset core shared encodings and instruction formats
`default_nettype none

package riscvPkg;

    // opcodes of the supported subset
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opRtype  = 7'b0110011;
    localparam logic [6:0] opItype  = 7'b0010011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;

    // alu operation select, gaps left for unused codes
    typedef enum logic [2:0] {
        aluAdd = 3'b000,
        aluSub = 3'b001,
        aluAnd = 3'b010,
        aluOr  = 3'b011,
        aluSlt = 3'b101
    } aluCtrlT;

    // immediate format select
    typedef enum logic [1:0] {
        immI = 2'b00,
        immS = 2'b01,
        immB = 2'b10,
        immJ = 2'b11
    } immSrcT;

    // write-back source select
    typedef enum logic [1:0] {
        resAlu     = 2'b00,
        resMem     = 2'b01,
        resPcPlus4 = 2'b10
    } resultSrcT;

    // one 32-bit word, seen through each encoding format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } rFmt;
        struct packed {
            logic [11:0] imm11to0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } iFmt;
        struct packed {
            logic [6:0] imm11to5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm4to0;
            logic [6:0] opcode;
        } sFmt;
        struct packed {
            logic       imm12;
            logic [5:0] imm10to5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4to1;
            logic       imm11;
            logic [6:0] opcode;
        } bFmt;
        struct packed {
            logic       imm20;
            logic [9:0] imm10to1;
            logic       imm11;
            logic [7:0] imm19to12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } jFmt;
    } instrT;

endpackage

`default_nettype wire
